/* dv/tb_soc_periph.sv */
`timescale 1ns/1ns

module tb_soc_periph;
    import soc_periph_pkg::*;

    localparam int DIV         = 16;
    localparam int N_BYTES     = 16;
    localparam int REG_CYCLES  = 3000;
    // 20 frames of 10 bits, plus the register tests, with double margin.
    localparam int CYCLE_LIMIT = 2 * (20 * 10 * DIV + REG_CYCLES);

    logic        core_clk;
    logic        arst_n;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        serial;
    logic        timer_irq;
    logic        soft_irq;
    logic        uart_irq;

    integer      seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;

    logic [31:0] exp_cmp_lo;
    logic [31:0] exp_cmp_hi;
    logic [31:0] exp_div;
    logic [31:0] exp_ie;
    logic [31:0] exp_msip;

    soc_periph_top #(
        .DEFAULT_DIV (DIV)
    ) uut (
        .core_clk    (core_clk),
        .arst_n_i    (arst_n),
        .paddr_i     (paddr),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .rxd_i       (serial),
        .txd_o       (serial),
        .timer_irq_o (timer_irq),
        .soft_irq_o  (soft_irq),
        .uart_irq_o  (uart_irq)
    );

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] clint_reg(input logic [15:0] ofs);
        return CLINT_BASE | {16'h0000, ofs};
    endfunction

    function automatic logic [31:0] uart_reg(input logic [15:0] ofs);
        return UART_BASE | {16'h0000, ofs};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Setup and access phases start on falling edges, response sampled 1 ns later.
    task automatic apb_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge core_clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge core_clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge core_clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge core_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(addr, 1'b1, data, rd, err);
        check_value("pslverr_o", 32'd0, {31'd0, err});
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(addr, 1'b0, 32'h0, data, err);
        check_value("pslverr_o", 32'd0, {31'd0, err});
    endtask

    task automatic wait_status(input int bit_idx, input logic level, output logic [31:0] st);
        do begin
            apb_read(uart_reg(UART_STATUS_OFS), st);
        end while (st[bit_idx] !== level);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [31:0] st;
        wait_status(ST_TX_BUSY, 1'b0, st);
        apb_write(uart_reg(UART_TXDATA_OFS), {24'h0, b});
    endtask

    task automatic check_regs();
        logic [31:0] rd;
        apb_read(clint_reg(CLINT_MTIMECMP_LO_OFS), rd);
        check_value("mtimecmp_lo", exp_cmp_lo, rd);
        apb_read(clint_reg(CLINT_MTIMECMP_HI_OFS), rd);
        check_value("mtimecmp_hi", exp_cmp_hi, rd);
        apb_read(clint_reg(CLINT_MSIP_OFS), rd);
        check_value("msip", exp_msip, rd);
        apb_read(uart_reg(UART_DIV_OFS), rd);
        check_value("divisor", exp_div, rd);
        apb_read(uart_reg(UART_IE_OFS), rd);
        check_value("uart_ie", exp_ie, rd);
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("[TEST] %s: pass", name);
        end else begin
            tests_failed++;
            $display("[TEST] %s: fail, %0d errors", name, errors - start);
        end
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        int          start;
        start = errors;
        check_value("pready_o", 32'd0, {31'd0, pready});
        check_value("pslverr_o", 32'd0, {31'd0, pslverr});
        check_value("txd_o", 32'd1, {31'd0, serial});
        check_value("timer_irq_o", 32'd0, {31'd0, timer_irq});
        check_value("soft_irq_o", 32'd0, {31'd0, soft_irq});
        check_value("uart_irq_o", 32'd0, {31'd0, uart_irq});
        apb_read(clint_reg(CLINT_MTIME_HI_OFS), rd);
        check_value("mtime_hi", 32'd0, rd);
        check_regs();
        finish_test("reset values", start);
    endtask

    task automatic test_readback();
        logic [31:0] v;
        int          start;
        start = errors;
        repeat (4) begin
            v = $random(seed);
            apb_write(clint_reg(CLINT_MTIMECMP_LO_OFS), v);
            exp_cmp_lo = v;
            v = $random(seed);
            apb_write(clint_reg(CLINT_MTIMECMP_HI_OFS), v);
            exp_cmp_hi = v;
            v = $random(seed);
            apb_write(uart_reg(UART_DIV_OFS), v);
            exp_div = {16'h0000, v[15:0]};
            v = $random(seed);
            apb_write(uart_reg(UART_IE_OFS), v);
            exp_ie = {31'd0, v[0]};
            check_regs();
        end
        apb_write(uart_reg(UART_DIV_OFS), DIV);
        exp_div = DIV;
        check_regs();
        finish_test("register readback", start);
    endtask

    task automatic test_soft_irq();
        logic [31:0] v;
        logic [31:0] rd;
        int          start;
        start = errors;
        repeat (6) begin
            v = $random(seed);
            apb_write(clint_reg(CLINT_MSIP_OFS), v);
            exp_msip = {31'd0, v[0]};
            apb_read(clint_reg(CLINT_MSIP_OFS), rd);
            check_value("msip", exp_msip, rd);
            check_value("soft_irq_o", exp_msip, {31'd0, soft_irq});
        end
        finish_test("soft interrupt", start);
    endtask

    task automatic test_timer();
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] cmp;
        logic        done;
        int          start;
        start = errors;
        apb_write(clint_reg(CLINT_MTIMECMP_HI_OFS), 32'hFFFF_FFFF);
        apb_write(clint_reg(CLINT_MTIMECMP_LO_OFS), 32'hFFFF_FFFF);
        exp_cmp_hi = 32'hFFFF_FFFF;
        exp_cmp_lo = 32'hFFFF_FFFF;
        check_value("timer_irq_o", 32'd0, {31'd0, timer_irq});

        // Keep V well below the wrap so the high half stays zero.
        v = $random(seed) & 32'h7FFF_FFFF;
        apb_write(clint_reg(CLINT_MTIME_HI_OFS), 32'h0);
        apb_write(clint_reg(CLINT_MTIME_LO_OFS), v);
        apb_read(clint_reg(CLINT_MTIME_LO_OFS), rd);
        assert (rd >= v && rd <= v + 32'd4) else begin
            $display("[FAIL] t=%0t mtime_lo expected 0x%08h..0x%08h actual 0x%08h",
                     $time, v, v + 32'd4, rd);
            errors++;
        end

        cmp = rd + 32'd50;
        apb_write(clint_reg(CLINT_MTIMECMP_HI_OFS), 32'h0);
        apb_write(clint_reg(CLINT_MTIMECMP_LO_OFS), cmp);
        exp_cmp_hi = 32'h0;
        exp_cmp_lo = cmp;
        done = 1'b0;
        while (!done) begin
            apb_read(clint_reg(CLINT_MTIME_LO_OFS), rd);
            if (rd < cmp) begin
                check_value("timer_irq_o", 32'd0, {31'd0, timer_irq});
            end else if (rd >= cmp + 32'd2) begin
                check_value("timer_irq_o", 32'd1, {31'd0, timer_irq});
                done = 1'b1;
            end
        end
        finish_test("timer", start);
    endtask

    task automatic test_loopback();
        logic [7:0]  b;
        logic [31:0] st;
        logic [31:0] rd;
        int          start;
        start = errors;
        apb_write(uart_reg(UART_IE_OFS), 32'd1);
        exp_ie = 32'd1;
        for (int i = 0; i < N_BYTES; i++) begin
            b = $random(seed);
            send_byte(b);
            wait_status(ST_RX_VALID, 1'b1, st);
            check_value("uart_irq_o", 32'd1, {31'd0, uart_irq});
            apb_read(uart_reg(UART_RXDATA_OFS), rd);
            check_value("rxdata", {24'h0, b}, rd);
            // The interrupt is registered one cycle behind rx_valid.
            @(negedge core_clk);
            check_value("uart_irq_o", 32'd0, {31'd0, uart_irq});
            apb_read(uart_reg(UART_STATUS_OFS), st);
            check_value("status.rx_valid", 32'd0, {31'd0, st[ST_RX_VALID]});
        end
        finish_test("uart loopback", start);
    endtask

    task automatic test_backpressure();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [31:0] st;
        logic [31:0] rd;
        int          start;
        start = errors;
        a = $random(seed);
        b = ~a;
        wait_status(ST_TX_BUSY, 1'b0, st);
        apb_write(uart_reg(UART_TXDATA_OFS), {24'h0, a});
        apb_write(uart_reg(UART_TXDATA_OFS), {24'h0, b});
        wait_status(ST_RX_VALID, 1'b1, st);
        apb_read(uart_reg(UART_RXDATA_OFS), rd);
        check_value("rxdata", {24'h0, a}, rd);
        wait_status(ST_TX_BUSY, 1'b0, st);
        check_value("status.rx_valid", 32'd0, {31'd0, st[ST_RX_VALID]});

        a = $random(seed);
        b = ~a;
        send_byte(a);
        wait_status(ST_RX_VALID, 1'b1, st);
        send_byte(b);
        wait_status(ST_RX_OVERRUN, 1'b1, st);
        apb_read(uart_reg(UART_RXDATA_OFS), rd);
        check_value("rxdata", {24'h0, b}, rd);
        apb_read(uart_reg(UART_STATUS_OFS), st);
        check_value("status.rx_overrun", 32'd0, {31'd0, st[ST_RX_OVERRUN]});
        check_value("status.rx_valid", 32'd0, {31'd0, st[ST_RX_VALID]});
        finish_test("back-pressure and overrun", start);
    endtask

    task automatic test_unmapped();
        logic [15:0] ofs_tbl [5];
        logic [15:0] upper;
        logic [31:0] addr;
        logic [31:0] rd;
        logic        err;
        int          start;
        start = errors;
        ofs_tbl[0] = CLINT_MSIP_OFS;
        ofs_tbl[1] = CLINT_MTIMECMP_LO_OFS;
        ofs_tbl[2] = CLINT_MTIMECMP_HI_OFS;
        ofs_tbl[3] = UART_DIV_OFS;
        ofs_tbl[4] = UART_IE_OFS;
        repeat (8) begin
            do begin
                upper = $random(seed);
            end while (upper == CLINT_BASE[31:16] || upper == UART_BASE[31:16]);
            addr = {upper, ofs_tbl[$unsigned($random(seed)) % 5]};
            apb_xfer(addr, 1'b1, $random(seed), rd, err);
            check_value("pslverr_o", 32'd1, {31'd0, err});
            check_value("prdata_o", 32'd0, rd);
            apb_xfer(addr, 1'b0, 32'h0, rd, err);
            check_value("pslverr_o", 32'd1, {31'd0, err});
            check_value("prdata_o", 32'd0, rd);
        end
        check_regs();
        finish_test("unmapped access", start);
    endtask

    initial begin
        seed         = 32'h793ebee6;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        arst_n       = 1'b0;
        paddr        = 32'h0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = 32'h0;
        exp_cmp_lo   = 32'hFFFF_FFFF;
        exp_cmp_hi   = 32'hFFFF_FFFF;
        exp_div      = DIV;
        exp_ie       = 32'd0;
        exp_msip     = 32'd0;

        repeat (2) @(posedge core_clk);
        @(negedge core_clk);
        arst_n = 1'b1;

        test_reset();
        test_readback();
        test_soft_irq();
        test_timer();
        test_loopback();
        test_backpressure();
        test_unmapped();

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* rtl/apb_decoder.sv */
`timescale 1ns/1ns

module apb_decoder (
    input  logic                              core_clk,
    input  logic                              arst_n_i,
    input  logic [soc_periph_pkg::ADDR_W-1:0] paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [soc_periph_pkg::DATA_W-1:0] pwdata_i,
    output logic [soc_periph_pkg::DATA_W-1:0] prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    apb_if.master                             clint_bus,
    apb_if.master                             uart_bus
);
    import soc_periph_pkg::*;

    logic hit_clint;
    logic hit_uart;
    logic sel_clint;
    logic sel_uart;
    logic err_q;

    assign hit_clint = (paddr_i[ADDR_W-1:16] == CLINT_BASE[ADDR_W-1:16]);
    assign hit_uart  = (paddr_i[ADDR_W-1:16] == UART_BASE[ADDR_W-1:16]);
    assign sel_clint = psel_i & hit_clint;
    assign sel_uart  = psel_i & hit_uart;

    assign clint_bus.paddr   = {{(ADDR_W-16){1'b0}}, paddr_i[15:0]};
    assign clint_bus.psel    = sel_clint;
    assign clint_bus.penable = penable_i & sel_clint;
    assign clint_bus.pwrite  = pwrite_i;
    assign clint_bus.pwdata  = pwdata_i;

    assign uart_bus.paddr    = {{(ADDR_W-16){1'b0}}, paddr_i[15:0]};
    assign uart_bus.psel     = sel_uart;
    assign uart_bus.penable  = penable_i & sel_uart;
    assign uart_bus.pwrite   = pwrite_i;
    assign uart_bus.pwdata   = pwdata_i;

    // Unmapped transfer is answered in its access cycle, flagged during setup.
    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= psel_i & ~penable_i & ~hit_clint & ~hit_uart;
        end
    end

    always_comb begin
        prdata_o  = '0;
        pready_o  = err_q;
        pslverr_o = err_q;
        if (sel_clint) begin
            prdata_o  = clint_bus.prdata;
            pready_o  = clint_bus.pready;
            pslverr_o = clint_bus.pslverr;
        end else if (sel_uart) begin
            prdata_o  = uart_bus.prdata;
            pready_o  = uart_bus.pready;
            pslverr_o = uart_bus.pslverr;
        end
    end

    a_one_device: assert property (@(posedge core_clk) disable iff (!arst_n_i)
        !(clint_bus.psel && uart_bus.psel))
        else $error("psel forwarded to both devices");

endmodule

/* rtl/apb_if.sv */
`timescale 1ns/1ns

interface apb_if;
    import soc_periph_pkg::*;

    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    modport master (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pready, pslverr
    );

endinterface

/* rtl/clint_regs.sv */
`timescale 1ns/1ns

module clint_regs (
    input  logic core_clk,
    input  logic arst_n_i,
    apb_if.slave bus,
    output logic timer_irq_o,
    output logic soft_irq_o
);
    import soc_periph_pkg::*;

    logic        pready_q;
    logic        access;
    logic        wr_en;
    logic [15:0] ofs;
    logic        msip_q;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        timer_irq_q;
    logic        soft_irq_q;

    assign ofs    = bus.paddr[15:0];
    assign access = bus.psel & bus.penable & pready_q;
    assign wr_en  = access & bus.pwrite;

    // Zero wait states, ready rises in the access cycle.
    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pready_q <= 1'b0;
        end else begin
            pready_q <= bus.psel & ~bus.penable;
        end
    end

    assign bus.pready  = pready_q;
    assign bus.pslverr = 1'b0;

    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            msip_q     <= 1'b0;
            mtimecmp_q <= '1;
        end else if (wr_en) begin
            case (ofs)
                CLINT_MSIP_OFS:        msip_q <= bus.pwdata[0];
                CLINT_MTIMECMP_LO_OFS: mtimecmp_q[31:0] <= bus.pwdata;
                CLINT_MTIMECMP_HI_OFS: mtimecmp_q[63:32] <= bus.pwdata;
                default: ;
            endcase
        end
    end

    // A write to either half loads it instead of counting that cycle.
    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q <= '0;
        end else if (wr_en && ofs == CLINT_MTIME_LO_OFS) begin
            mtime_q <= {mtime_q[63:32], bus.pwdata};
        end else if (wr_en && ofs == CLINT_MTIME_HI_OFS) begin
            mtime_q <= {bus.pwdata, mtime_q[31:0]};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_comb begin
        case (ofs)
            CLINT_MSIP_OFS:        bus.prdata = {{(DATA_W-1){1'b0}}, msip_q};
            CLINT_MTIMECMP_LO_OFS: bus.prdata = mtimecmp_q[31:0];
            CLINT_MTIMECMP_HI_OFS: bus.prdata = mtimecmp_q[63:32];
            CLINT_MTIME_LO_OFS:    bus.prdata = mtime_q[31:0];
            CLINT_MTIME_HI_OFS:    bus.prdata = mtime_q[63:32];
            default:               bus.prdata = '0;
        endcase
    end

    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timer_irq_q <= 1'b0;
            soft_irq_q  <= 1'b0;
        end else begin
            timer_irq_q <= (mtime_q >= mtimecmp_q);
            soft_irq_q  <= msip_q;
        end
    end

    assign timer_irq_o = timer_irq_q;
    assign soft_irq_o  = soft_irq_q;

    a_ready_in_psel: assert property (@(posedge core_clk) disable iff (!arst_n_i)
        bus.pready |-> bus.psel)
        else $error("CLINT pready outside a transfer");

endmodule

/* rtl/soc_periph_pkg.sv */
package soc_periph_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int DIV_W  = 16;

    // Regions are matched on the upper 16 address bits.
    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] UART_BASE  = 32'h1000_0000;

    localparam logic [15:0] CLINT_MSIP_OFS        = 16'h0000;
    localparam logic [15:0] CLINT_MTIMECMP_LO_OFS = 16'h4000;
    localparam logic [15:0] CLINT_MTIMECMP_HI_OFS = 16'h4004;
    localparam logic [15:0] CLINT_MTIME_LO_OFS    = 16'hBFF8;
    localparam logic [15:0] CLINT_MTIME_HI_OFS    = 16'hBFFC;

    localparam logic [15:0] UART_TXDATA_OFS = 16'h0000;
    localparam logic [15:0] UART_RXDATA_OFS = 16'h0004;
    localparam logic [15:0] UART_STATUS_OFS = 16'h0008;
    localparam logic [15:0] UART_DIV_OFS    = 16'h000C;
    localparam logic [15:0] UART_IE_OFS     = 16'h0010;

    // Bit positions in the UART status word.
    localparam int ST_RX_VALID   = 0;
    localparam int ST_TX_BUSY    = 1;
    localparam int ST_RX_OVERRUN = 2;

endpackage

/* rtl/soc_periph_top.sv */
`timescale 1ns/1ns

module soc_periph_top #(
    parameter logic [soc_periph_pkg::DIV_W-1:0] DEFAULT_DIV = 16
) (
    input  logic                              core_clk,
    input  logic                              arst_n_i,
    input  logic [soc_periph_pkg::ADDR_W-1:0] paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [soc_periph_pkg::DATA_W-1:0] pwdata_i,
    output logic [soc_periph_pkg::DATA_W-1:0] prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    input  logic                              rxd_i,
    output logic                              txd_o,
    output logic                              timer_irq_o,
    output logic                              soft_irq_o,
    output logic                              uart_irq_o
);
    import soc_periph_pkg::*;

    logic [DIV_W-1:0] divisor;
    logic             tx_start;
    logic [7:0]       tx_byte;
    logic             tx_busy;
    logic             rx_done;
    logic [7:0]       rx_byte;

    apb_if clint_apb ();
    apb_if uart_apb ();

    apb_decoder u_decoder (
        .core_clk  (core_clk),
        .arst_n_i  (arst_n_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .clint_bus (clint_apb.master),
        .uart_bus  (uart_apb.master)
    );

    clint_regs u_clint (
        .core_clk    (core_clk),
        .arst_n_i    (arst_n_i),
        .bus         (clint_apb.slave),
        .timer_irq_o (timer_irq_o),
        .soft_irq_o  (soft_irq_o)
    );

    uart_regs #(
        .DEFAULT_DIV (DEFAULT_DIV)
    ) u_uart_regs (
        .core_clk   (core_clk),
        .arst_n_i   (arst_n_i),
        .bus        (uart_apb.slave),
        .divisor_o  (divisor),
        .tx_start_o (tx_start),
        .tx_byte_o  (tx_byte),
        .tx_busy_i  (tx_busy),
        .rx_done_i  (rx_done),
        .rx_byte_i  (rx_byte),
        .irq_o      (uart_irq_o)
    );

    uart_core u_uart_core (
        .core_clk   (core_clk),
        .arst_n_i   (arst_n_i),
        .divisor_i  (divisor),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_busy_o  (tx_busy),
        .rx_done_o  (rx_done),
        .rx_byte_o  (rx_byte),
        .rxd_i      (rxd_i),
        .txd_o      (txd_o)
    );

endmodule

/* rtl/uart_core.sv */
`timescale 1ns/1ns

module uart_core (
    input  logic                             core_clk,
    input  logic                             arst_n_i,
    input  logic [soc_periph_pkg::DIV_W-1:0] divisor_i,
    input  logic                             tx_start_i,
    input  logic [7:0]                       tx_byte_i,
    output logic                             tx_busy_o,
    output logic                             rx_done_o,
    output logic [7:0]                       rx_byte_o,
    input  logic                             rxd_i,
    output logic                             txd_o
);
    import soc_periph_pkg::*;

    logic [DIV_W-1:0] tx_cnt_q;
    logic [3:0]       tx_bit_q;
    logic [8:0]       tx_shift_q;
    logic             tx_busy_q;
    logic             txd_q;

    logic             rxd_s1_q;
    logic             rxd_s2_q;
    logic             rxd_prev_q;
    logic             rx_active_q;
    logic [DIV_W-1:0] rx_cnt_q;
    logic [3:0]       rx_bit_q;
    logic [7:0]       rx_shift_q;
    logic             rx_done_q;

    // Transmitter, start bit driven at once, then data LSB first and stop.
    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_busy_q <= 1'b0;
            txd_q     <= 1'b1;
            tx_cnt_q  <= '0;
            tx_bit_q  <= '0;
        end else if (!tx_busy_q) begin
            if (tx_start_i) begin
                tx_busy_q <= 1'b1;
                txd_q     <= 1'b0;
                tx_cnt_q  <= '0;
                tx_bit_q  <= '0;
            end
        end else if (tx_cnt_q == divisor_i - DIV_W'(1)) begin
            tx_cnt_q <= '0;
            if (tx_bit_q == 4'd9) begin
                tx_busy_q <= 1'b0;
            end else begin
                txd_q    <= tx_shift_q[0];
                tx_bit_q <= tx_bit_q + 4'd1;
            end
        end else begin
            tx_cnt_q <= tx_cnt_q + DIV_W'(1);
        end
    end

    always_ff @(posedge core_clk) begin
        if (!tx_busy_q && tx_start_i) begin
            tx_shift_q <= {1'b1, tx_byte_i};
        end else if (tx_busy_q && tx_cnt_q == divisor_i - DIV_W'(1)) begin
            tx_shift_q <= {1'b1, tx_shift_q[8:1]};
        end
    end

    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rxd_s1_q   <= 1'b1;
            rxd_s2_q   <= 1'b1;
            rxd_prev_q <= 1'b1;
        end else begin
            rxd_s1_q   <= rxd_i;
            rxd_s2_q   <= rxd_s1_q;
            rxd_prev_q <= rxd_s2_q;
        end
    end

    // Receiver samples mid-bit, first at half a divisor after the start edge.
    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_active_q <= 1'b0;
            rx_cnt_q    <= '0;
            rx_bit_q    <= '0;
            rx_done_q   <= 1'b0;
        end else begin
            rx_done_q <= 1'b0;
            if (!rx_active_q) begin
                if (rxd_prev_q && !rxd_s2_q) begin
                    rx_active_q <= 1'b1;
                    rx_cnt_q    <= divisor_i >> 1;
                    rx_bit_q    <= '0;
                end
            end else if (rx_cnt_q != '0) begin
                rx_cnt_q <= rx_cnt_q - DIV_W'(1);
            end else begin
                rx_cnt_q <= divisor_i - DIV_W'(1);
                rx_bit_q <= rx_bit_q + 4'd1;
                if (rx_bit_q == 4'd0 && rxd_s2_q) begin
                    // Glitch, not a real start bit.
                    rx_active_q <= 1'b0;
                end else if (rx_bit_q == 4'd9) begin
                    rx_active_q <= 1'b0;
                    rx_done_q   <= rxd_s2_q;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (rx_active_q && rx_cnt_q == '0 && rx_bit_q != 4'd0 && rx_bit_q != 4'd9) begin
            rx_shift_q <= {rxd_s2_q, rx_shift_q[7:1]};
        end
    end

    assign tx_busy_o = tx_busy_q;
    assign txd_o     = txd_q;
    assign rx_done_o = rx_done_q;
    assign rx_byte_o = rx_shift_q;

endmodule

/* rtl/uart_regs.sv */
`timescale 1ns/1ns

module uart_regs #(
    parameter logic [soc_periph_pkg::DIV_W-1:0] DEFAULT_DIV = 16
) (
    input  logic                             core_clk,
    input  logic                             arst_n_i,
    apb_if.slave                             bus,
    output logic [soc_periph_pkg::DIV_W-1:0] divisor_o,
    output logic                             tx_start_o,
    output logic [7:0]                       tx_byte_o,
    input  logic                             tx_busy_i,
    input  logic                             rx_done_i,
    input  logic [7:0]                       rx_byte_i,
    output logic                             irq_o
);
    import soc_periph_pkg::*;

    logic              pready_q;
    logic              rd_en;
    logic              wr_en;
    logic [15:0]       ofs;
    logic [DIV_W-1:0]  div_q;
    logic              ie_q;
    logic [7:0]        rx_byte_q;
    logic              rx_valid_q;
    logic              rx_overrun_q;
    logic              tx_start_q;
    logic [7:0]        tx_byte_q;
    logic              tx_busy;
    logic              irq_q;
    logic [DATA_W-1:0] status;

    assign ofs   = bus.paddr[15:0];
    assign rd_en = bus.psel & bus.penable & pready_q & ~bus.pwrite;
    assign wr_en = bus.psel & bus.penable & pready_q & bus.pwrite;

    // A pending start counts as busy until the core takes it.
    assign tx_busy = tx_busy_i | tx_start_q;

    always_ff @(posedge core_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pready_q     <= 1'b0;
            div_q        <= DEFAULT_DIV;
            ie_q         <= 1'b0;
            rx_valid_q   <= 1'b0;
            rx_overrun_q <= 1'b0;
            tx_start_q   <= 1'b0;
            irq_q        <= 1'b0;
        end else begin
            pready_q   <= bus.psel & ~bus.penable;
            tx_start_q <= wr_en && ofs == UART_TXDATA_OFS && !tx_busy;
            irq_q      <= rx_valid_q & ie_q;
            if (wr_en && ofs == UART_DIV_OFS) begin
                div_q <= bus.pwdata[DIV_W-1:0];
            end
            if (wr_en && ofs == UART_IE_OFS) begin
                ie_q <= bus.pwdata[0];
            end
            if (rd_en && ofs == UART_RXDATA_OFS) begin
                rx_valid_q <= 1'b0;
            end
            if (rd_en && ofs == UART_STATUS_OFS) begin
                rx_overrun_q <= 1'b0;
            end
            // New byte wins over a clearing read in the same cycle.
            if (rx_done_i) begin
                rx_valid_q <= 1'b1;
                if (rx_valid_q && !(rd_en && ofs == UART_RXDATA_OFS)) begin
                    rx_overrun_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (rx_done_i) begin
            rx_byte_q <= rx_byte_i;
        end
        if (wr_en && ofs == UART_TXDATA_OFS) begin
            tx_byte_q <= bus.pwdata[7:0];
        end
    end

    always_comb begin
        status                = '0;
        status[ST_RX_VALID]   = rx_valid_q;
        status[ST_TX_BUSY]    = tx_busy;
        status[ST_RX_OVERRUN] = rx_overrun_q;
        case (ofs)
            UART_RXDATA_OFS: bus.prdata = {{(DATA_W-8){1'b0}}, rx_byte_q};
            UART_STATUS_OFS: bus.prdata = status;
            UART_DIV_OFS:    bus.prdata = {{(DATA_W-DIV_W){1'b0}}, div_q};
            UART_IE_OFS:     bus.prdata = {{(DATA_W-1){1'b0}}, ie_q};
            default:         bus.prdata = '0;
        endcase
    end

    assign bus.pready  = pready_q;
    assign bus.pslverr = 1'b0;
    assign divisor_o   = div_q;
    assign tx_start_o  = tx_start_q;
    assign tx_byte_o   = tx_byte_q;
    assign irq_o       = irq_q;

    a_no_start_busy: assert property (@(posedge core_clk) disable iff (!arst_n_i)
        tx_start_o |-> !tx_busy_i)
        else $error("tx_start issued while transmitter busy");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then decide on the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_soc_periph \
    && ./obj_dir/Vtb_soc_periph > sim.log 2>&1 \
    || echo "build or run returned an error"

cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1

/* tb.f */
rtl/soc_periph_pkg.sv
rtl/apb_if.sv
rtl/apb_decoder.sv
rtl/clint_regs.sv
rtl/uart_regs.sv
rtl/uart_core.sv
rtl/soc_periph_top.sv
dv/tb_soc_periph.sv
